/* verilog.f */
+incdir+sim
hdl/kbd_pkg.sv
hdl/axil_pkg.sv
hdl/ps2_rx.sv
hdl/scancode_decoder.sv
hdl/key_event_fifo.sv
hdl/kbd_axil_regs.sv
hdl/kbd_ctrl_top.sv
sim/kbd_tb.sv

/* run_sim.sh */
#!/bin/sh
# build and run the keyboard controller testbench with Verilator
rm -f sim.log
verilator --binary --timing --assert --timescale 1ns/10ps \
    --top-module kbd_tb -f verilog.f -o kbd_sim \
    && ./obj_dir/kbd_sim > sim.log 2>&1
cat sim.log 2>/dev/null
grep -q "Simulation PASSED" sim.log \
    && echo "run passed" \
    || { echo "run failed"; exit 1; }

/* sim/kbd_tb_tasks.svh */
`ifndef KBD_TB_TASKS_SVH
`define KBD_TB_TASKS_SVH

// one device-to-host frame of start, 8 data bits lsb first, odd parity and stop
// data changes with the rising PS/2 clock and the host samples on the falling one
task automatic ps2_send(input kbd_pkg::scan_code_t code, input logic bad_parity,
                        input logic bad_stop);
    logic [10:0] frame;
    logic        parity;
    int          i;
    parity = ~^code;
    if (bad_parity) parity = ~parity;
    frame = {~bad_stop, parity, code, 1'b0};
    @(posedge clk);
    for (i = 0; i < 11; i++) begin
        ps2_data <= frame[i];
        repeat (HALF_PERIOD) @(posedge clk);
        ps2_clk <= 1'b0;
        repeat (HALF_PERIOD) @(posedge clk);
        ps2_clk <= 1'b1;
    end
    // line back to idle
    ps2_data <= 1'b1;
endtask

task automatic axil_write(input logic [3:0] addr, input logic [31:0] data,
                          output logic [1:0] resp);
    @(posedge clk);
    axil_req.awvalid <= 1'b1;
    axil_req.wvalid  <= 1'b1;
    axil_req.awaddr  <= addr;
    axil_req.wdata   <= data;
    axil_req.wstrb   <= 4'hF;
    axil_req.bready  <= 1'b1;
    @(negedge clk);
    while (!axil_rsp.awready) @(negedge clk);
    check_value("wready", 32'd1, 32'(axil_rsp.wready));
    @(posedge clk);
    axil_req.awvalid <= 1'b0;
    axil_req.wvalid  <= 1'b0;
    @(negedge clk);
    while (!axil_rsp.bvalid) @(negedge clk);
    resp = axil_rsp.bresp;
    @(posedge clk);
    axil_req.bready <= 1'b0;
endtask

// hold keeps rready low for that many cycles after rvalid
task automatic axil_read(input logic [3:0] addr, input int hold,
                         output logic [31:0] data, output logic [1:0] resp);
    @(posedge clk);
    axil_req.arvalid <= 1'b1;
    axil_req.araddr  <= addr;
    axil_req.rready  <= 1'b0;
    @(negedge clk);
    while (!axil_rsp.arready) @(negedge clk);
    @(posedge clk);
    axil_req.arvalid <= 1'b0;
    @(negedge clk);
    while (!axil_rsp.rvalid) @(negedge clk);
    data = axil_rsp.rdata;
    resp = axil_rsp.rresp;
    repeat (hold) begin
        @(negedge clk);
        check_value("rvalid", 32'd1, 32'(axil_rsp.rvalid));
        check_value("rdata", data, axil_rsp.rdata);
    end
    @(posedge clk);
    axil_req.rready <= 1'b1;
    @(posedge clk);
    axil_req.rready <= 1'b0;
endtask

`endif

/* sim/kbd_tb.sv */
`timescale 1ns/10ps

module kbd_tb;

    localparam int FIFO_DEPTH   = 4;
    localparam int HALF_PERIOD  = 20;
    localparam int FRAME_CYCLES = 22 * HALF_PERIOD;
    localparam int N_FRAMES     = 60;
    localparam int BUS_CYCLES   = 4000;
    // run limit with half again as much margin
    localparam int TIMEOUT_CYCLES = (N_FRAMES * FRAME_CYCLES + BUS_CYCLES) * 3 / 2;

    logic                clk;
    logic                reset;
    logic                ps2_clk;
    logic                ps2_data;
    axil_pkg::axil_req_t axil_req;
    axil_pkg::axil_rsp_t axil_rsp;

    // reference model of prefix decoding, queue and sticky bits
    kbd_pkg::key_event_t exp_q[$];
    logic                ext_pend;
    logic                brk_pend;
    logic                rx_enabled;
    logic                ovf_flag;
    logic                ferr_flag;

    int seed = 52169;
    int err_count;
    int test_err_start;
    int tests_run;
    int tests_failed;
    int cycles;

    kbd_ctrl_top #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) uut (
        .clk_i      (clk),
        .reset_i    (reset),
        .ps2_clk_i  (ps2_clk),
        .ps2_data_i (ps2_data),
        .axil_req_i (axil_req),
        .axil_rsp_o (axil_rsp)
    );

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        assert (actual === expected) else begin
            $display("Error at %0t ns: %s expected 0x%0h, got 0x%0h",
                     $time, name, expected, actual);
            err_count++;
        end
    endtask

    `include "kbd_tb_tasks.svh"

    task automatic random_code(output kbd_pkg::scan_code_t code);
        code = 8'($random(seed));
        // prefix bytes would change the meaning of the sequence
        while (code == kbd_pkg::PREFIX_EXT || code == kbd_pkg::PREFIX_BRK) begin
            code = 8'($random(seed));
        end
    endtask

    // reference for good frames follows the E0/F0 prefix rule
    task automatic send_byte(input kbd_pkg::scan_code_t code);
        kbd_pkg::key_event_t ev;
        ps2_send(code, 1'b0, 1'b0);
        if (code == kbd_pkg::PREFIX_EXT) begin
            ext_pend = 1'b1;
        end else if (code == kbd_pkg::PREFIX_BRK) begin
            brk_pend = 1'b1;
        end else begin
            ev.code     = code;
            ev.extended = ext_pend;
            ev.brk      = brk_pend;
            ext_pend    = 1'b0;
            brk_pend    = 1'b0;
            if (rx_enabled && exp_q.size() < FIFO_DEPTH) begin
                exp_q.push_back(ev);
            end else if (rx_enabled) begin
                ovf_flag = 1'b1;
            end
        end
    endtask

    task automatic send_bad(input kbd_pkg::scan_code_t code, input logic bad_parity,
                            input logic bad_stop);
        ps2_send(code, bad_parity, bad_stop);
        ext_pend  = 1'b0;
        brk_pend  = 1'b0;
        ferr_flag = 1'b1;
    endtask

    task automatic write_reg(input logic [3:0] addr, input logic [31:0] data);
        logic [1:0] resp;
        axil_write(addr, data, resp);
        check_value("bresp", 32'(axil_pkg::OKAY), 32'(resp));
        if (addr == axil_pkg::STATUS_ADDR && data[1]) ovf_flag = 1'b0;
        if (addr == axil_pkg::STATUS_ADDR && data[2]) ferr_flag = 1'b0;
        if (addr == axil_pkg::CTRL_ADDR) rx_enabled = data[0];
    endtask

    // empty reference means the read must return 0
    task automatic read_event();
        logic [31:0]         data;
        logic [1:0]          resp;
        logic [31:0]         expected;
        kbd_pkg::key_event_t ev;
        expected = 32'd0;
        if (exp_q.size() != 0) begin
            ev       = exp_q.pop_front();
            expected = {22'd0, ev.brk, ev.extended, ev.code};
        end
        axil_read(axil_pkg::DATA_ADDR, 0, data, resp);
        check_value("rdata", expected, data);
        check_value("rresp", 32'(axil_pkg::OKAY), 32'(resp));
    endtask

    task automatic check_status();
        logic [31:0] data;
        logic [1:0]  resp;
        axil_read(axil_pkg::STATUS_ADDR, 0, data, resp);
        check_value("status", {29'd0, ferr_flag, ovf_flag, exp_q.size() != 0}, data);
    endtask

    task automatic check_ctrl();
        logic [31:0] data;
        logic [1:0]  resp;
        axil_read(axil_pkg::CTRL_ADDR, 0, data, resp);
        check_value("ctrl", {31'd0, rx_enabled}, data);
    endtask

    task automatic finish_test(input string name);
        tests_run++;
        if (err_count > test_err_start) tests_failed++;
        $display("test %0d (%s) done, %0d errors", tests_run, name, err_count - test_err_start);
        test_err_start = err_count;
    endtask

    initial begin : clock_gen
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    initial begin : watchdog
        cycles = 0;
        while (cycles < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout, run still going after %0d cycles", cycles);
        $display("Simulation FAILED");
        $finish;
    end

    initial begin : stimulus
        kbd_pkg::scan_code_t code;
        logic [31:0]         data;
        logic [1:0]          resp;
        kbd_pkg::key_event_t ev;
        int                  i;
        reset      <= 1'b1;
        ps2_clk    <= 1'b1;
        ps2_data   <= 1'b1;
        axil_req   <= '0;
        ext_pend   = 1'b0;
        brk_pend   = 1'b0;
        rx_enabled = 1'b1;
        ovf_flag   = 1'b0;
        ferr_flag  = 1'b0;
        err_count      = 0;
        test_err_start = 0;
        tests_run      = 0;
        tests_failed   = 0;
        repeat (8) @(posedge clk);
        reset <= 1'b0;

        random_code(code);
        send_byte(code);
        read_event();
        check_status();
        finish_test("make code");

        // extended, break, extended break
        random_code(code);
        send_byte(kbd_pkg::PREFIX_EXT);
        send_byte(code);
        random_code(code);
        send_byte(kbd_pkg::PREFIX_BRK);
        send_byte(code);
        random_code(code);
        send_byte(kbd_pkg::PREFIX_EXT);
        send_byte(kbd_pkg::PREFIX_BRK);
        send_byte(code);
        repeat (3) read_event();
        check_status();
        finish_test("prefix flags");

        random_code(code);
        send_bad(code, 1'b1, 1'b0);
        check_status();
        write_reg(axil_pkg::STATUS_ADDR, 32'h4);
        check_status();
        random_code(code);
        send_bad(code, 1'b0, 1'b1);
        check_status();
        write_reg(axil_pkg::STATUS_ADDR, 32'h4);
        check_status();
        random_code(code);
        send_byte(code);
        read_event();
        finish_test("frame errors");

        for (i = 0; i < FIFO_DEPTH + 2; i++) begin
            random_code(code);
            send_byte(code);
        end
        check_status();
        // one read past the stored events
        repeat (FIFO_DEPTH + 1) read_event();
        write_reg(axil_pkg::STATUS_ADDR, 32'h2);
        check_status();
        finish_test("overflow");

        write_reg(axil_pkg::CTRL_ADDR, 32'h0);
        check_ctrl();
        repeat (2) begin
            random_code(code);
            send_byte(code);
        end
        check_status();
        write_reg(axil_pkg::CTRL_ADDR, 32'h1);
        check_ctrl();
        repeat (2) begin
            random_code(code);
            send_byte(code);
        end
        repeat (2) read_event();
        check_status();
        finish_test("receive enable");

        axil_write(4'hC, 32'h1, resp);
        check_value("bresp", 32'(axil_pkg::SLVERR), 32'(resp));
        axil_read(4'hC, 4, data, resp);
        check_value("rresp", 32'(axil_pkg::SLVERR), 32'(resp));
        check_value("rdata", 32'd0, data);
        // held response with a real event in it
        random_code(code);
        send_byte(code);
        ev = exp_q.pop_front();
        axil_read(axil_pkg::DATA_ADDR, 6, data, resp);
        check_value("rdata", {22'd0, ev.brk, ev.extended, ev.code}, data);
        check_value("rresp", 32'(axil_pkg::OKAY), 32'(resp));
        finish_test("bus errors and back-pressure");

        $display("%0d tests, %0d failed, %0d errors", tests_run, tests_failed, err_count);
        if (err_count == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

/* hdl/kbd_ctrl_top.sv */
`timescale 1ns/10ps

module kbd_ctrl_top #(
    parameter int FIFO_DEPTH = 8
) (
    input  logic                clk_i,
    input  logic                reset_i,
    input  logic                ps2_clk_i,
    input  logic                ps2_data_i,
    input  axil_pkg::axil_req_t axil_req_i,
    output axil_pkg::axil_rsp_t axil_rsp_o
);

    kbd_pkg::scan_code_t frame;
    logic                frame_valid;
    logic                frame_err;
    kbd_pkg::key_event_t dec_event;
    logic                dec_event_valid;
    kbd_pkg::key_event_t fifo_event;
    logic                fifo_not_empty;
    logic                fifo_overflow;
    logic                fifo_pop;
    logic                rx_enable;

    ps2_rx u_ps2_rx (
        .clk_i         (clk_i),
        .reset_i       (reset_i),
        .ps2_clk_i     (ps2_clk_i),
        .ps2_data_i    (ps2_data_i),
        .frame_o       (frame),
        .frame_valid_o (frame_valid),
        .frame_err_o   (frame_err)
    );

    scancode_decoder u_decoder (
        .clk_i         (clk_i),
        .reset_i       (reset_i),
        .frame_i       (frame),
        .frame_valid_i (frame_valid),
        .frame_err_i   (frame_err),
        .enable_i      (rx_enable),
        .event_o       (dec_event),
        .event_valid_o (dec_event_valid)
    );

    key_event_fifo #(
        .DEPTH (FIFO_DEPTH)
    ) u_fifo (
        .clk_i       (clk_i),
        .reset_i     (reset_i),
        .push_i      (dec_event_valid),
        .event_i     (dec_event),
        .pop_i       (fifo_pop),
        .event_o     (fifo_event),
        .not_empty_o (fifo_not_empty),
        .overflow_o  (fifo_overflow)
    );

    kbd_axil_regs u_regs (
        .clk_i            (clk_i),
        .reset_i          (reset_i),
        .axil_req_i       (axil_req_i),
        .fifo_event_i     (fifo_event),
        .fifo_not_empty_i (fifo_not_empty),
        .fifo_overflow_i  (fifo_overflow),
        .frame_err_i      (frame_err),
        .axil_rsp_o       (axil_rsp_o),
        .fifo_pop_o       (fifo_pop),
        .enable_o         (rx_enable)
    );

endmodule

/* hdl/kbd_axil_regs.sv */
`timescale 1ns/10ps

module kbd_axil_regs (
    input  logic                clk_i,
    input  logic                reset_i,
    input  axil_pkg::axil_req_t axil_req_i,
    input  kbd_pkg::key_event_t fifo_event_i,
    input  logic                fifo_not_empty_i,
    input  logic                fifo_overflow_i,
    input  logic                frame_err_i,
    output axil_pkg::axil_rsp_t axil_rsp_o,
    output logic                fifo_pop_o,
    output logic                enable_o
);

    logic            awready_r;
    logic            bvalid_r;
    axil_pkg::resp_t bresp_r;
    logic            arready_r;
    logic            rvalid_r;
    logic [31:0]     rdata_r;
    axil_pkg::resp_t rresp_r;

    // sticky status and control bits
    logic ovf_r;
    logic ferr_r;
    logic enable_r;

    logic                wr_fire_w;
    logic                rd_fire_w;
    axil_pkg::reg_addr_t waddr_w;
    axil_pkg::reg_addr_t raddr_w;

    assign waddr_w   = axil_pkg::reg_addr_t'(axil_req_i.awaddr);
    assign raddr_w   = axil_pkg::reg_addr_t'(axil_req_i.araddr);
    assign wr_fire_w = awready_r && axil_req_i.awvalid && axil_req_i.wvalid;
    assign rd_fire_w = arready_r && axil_req_i.arvalid;

    // pop only on a DATA read that has something to return
    assign fifo_pop_o = rd_fire_w && (raddr_w == axil_pkg::DATA_ADDR) && fifo_not_empty_i;

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            awready_r <= 1'b0;
            bvalid_r  <= 1'b0;
            arready_r <= 1'b0;
            rvalid_r  <= 1'b0;
        end else begin
            // one-cycle ready pulses, held off while a response waits
            awready_r <= !awready_r && axil_req_i.awvalid && axil_req_i.wvalid && !bvalid_r;
            arready_r <= !arready_r && axil_req_i.arvalid && !rvalid_r;
            if (wr_fire_w) begin
                bvalid_r <= 1'b1;
            end else if (axil_req_i.bready) begin
                bvalid_r <= 1'b0;
            end
            if (rd_fire_w) begin
                rvalid_r <= 1'b1;
            end else if (axil_req_i.rready) begin
                rvalid_r <= 1'b0;
            end
        end
    end

    // register writes and sticky bits, a new event wins over a clear
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            ovf_r    <= 1'b0;
            ferr_r   <= 1'b0;
            enable_r <= 1'b1;
        end else begin
            if (wr_fire_w && axil_req_i.wstrb[0]) begin
                if (waddr_w == axil_pkg::STATUS_ADDR) begin
                    if (axil_req_i.wdata[1]) ovf_r <= 1'b0;
                    if (axil_req_i.wdata[2]) ferr_r <= 1'b0;
                end
                if (waddr_w == axil_pkg::CTRL_ADDR) begin
                    enable_r <= axil_req_i.wdata[0];
                end
            end
            if (fifo_overflow_i) ovf_r <= 1'b1;
            if (frame_err_i) ferr_r <= 1'b1;
        end
    end

    // response payload
    always_ff @(posedge clk_i) begin
        if (wr_fire_w) begin
            case (waddr_w)
                axil_pkg::STATUS_ADDR, axil_pkg::DATA_ADDR, axil_pkg::CTRL_ADDR: begin
                    bresp_r <= axil_pkg::OKAY;
                end
                default: bresp_r <= axil_pkg::SLVERR;
            endcase
        end
        if (rd_fire_w) begin
            rresp_r <= axil_pkg::OKAY;
            case (raddr_w)
                axil_pkg::STATUS_ADDR: rdata_r <= {29'd0, ferr_r, ovf_r, fifo_not_empty_i};
                axil_pkg::DATA_ADDR:   rdata_r <= fifo_not_empty_i ? {22'd0, fifo_event_i} : '0;
                axil_pkg::CTRL_ADDR:   rdata_r <= {31'd0, enable_r};
                default: begin
                    rdata_r <= '0;
                    rresp_r <= axil_pkg::SLVERR;
                end
            endcase
        end
    end

    always_comb begin
        axil_rsp_o.awready = awready_r;
        axil_rsp_o.wready  = awready_r;
        axil_rsp_o.bvalid  = bvalid_r;
        axil_rsp_o.bresp   = bresp_r;
        axil_rsp_o.arready = arready_r;
        axil_rsp_o.rvalid  = rvalid_r;
        axil_rsp_o.rdata   = rdata_r;
        axil_rsp_o.rresp   = rresp_r;
    end

    assign enable_o = enable_r;

endmodule

/* hdl/key_event_fifo.sv */
`timescale 1ns/10ps

module key_event_fifo #(
    parameter int DEPTH = 8
) (
    input  logic                clk_i,
    input  logic                reset_i,
    input  logic                push_i,
    input  kbd_pkg::key_event_t event_i,
    input  logic                pop_i,
    output kbd_pkg::key_event_t event_o,
    output logic                not_empty_o,
    output logic                overflow_o
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    kbd_pkg::key_event_t mem [DEPTH];

    logic [PTR_W-1:0] wr_ptr_r;
    logic [PTR_W-1:0] rd_ptr_r;
    logic [CNT_W-1:0] count_r;

    logic full_w;
    logic do_push_w;
    logic do_pop_w;

    assign full_w    = (count_r == CNT_W'(DEPTH));
    assign do_push_w = push_i && !full_w;
    assign do_pop_w  = pop_i && not_empty_o;

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            wr_ptr_r <= '0;
            rd_ptr_r <= '0;
            count_r  <= '0;
        end else begin
            if (do_push_w) begin
                wr_ptr_r <= (wr_ptr_r == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr_r + 1'b1;
            end
            if (do_pop_w) begin
                rd_ptr_r <= (rd_ptr_r == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr_r + 1'b1;
            end
            if (do_push_w && !do_pop_w) begin
                count_r <= count_r + 1'b1;
            end else if (do_pop_w && !do_push_w) begin
                count_r <= count_r - 1'b1;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (do_push_w) begin
            mem[wr_ptr_r] <= event_i;
        end
    end

    // head of queue is visible before the pop
    assign event_o     = mem[rd_ptr_r];
    assign not_empty_o = (count_r != '0);
    // full push drops the event
    assign overflow_o  = push_i && full_w;

endmodule

/* hdl/scancode_decoder.sv */
`timescale 1ns/10ps

module scancode_decoder (
    input  logic                clk_i,
    input  logic                reset_i,
    input  kbd_pkg::scan_code_t frame_i,
    input  logic                frame_valid_i,
    input  logic                frame_err_i,
    input  logic                enable_i,
    output kbd_pkg::key_event_t event_o,
    output logic                event_valid_o
);

    // prefixes seen since the last complete event
    logic ext_pend_r;
    logic brk_pend_r;

    logic is_ext_w;
    logic is_brk_w;
    logic is_code_w;

    assign is_ext_w  = frame_valid_i && (frame_i == kbd_pkg::PREFIX_EXT);
    assign is_brk_w  = frame_valid_i && (frame_i == kbd_pkg::PREFIX_BRK);
    assign is_code_w = frame_valid_i && !is_ext_w && !is_brk_w;

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            ext_pend_r    <= 1'b0;
            brk_pend_r    <= 1'b0;
            event_valid_o <= 1'b0;
        end else begin
            event_valid_o <= 1'b0;
            if (frame_err_i) begin
                // a broken frame loses any half-built sequence
                ext_pend_r <= 1'b0;
                brk_pend_r <= 1'b0;
            end else if (is_ext_w) begin
                ext_pend_r <= 1'b1;
            end else if (is_brk_w) begin
                brk_pend_r <= 1'b1;
            end else if (is_code_w) begin
                ext_pend_r <= 1'b0;
                brk_pend_r <= 1'b0;
                // dropped here when receive is disabled
                event_valid_o <= enable_i;
            end
        end
    end

    // event payload
    always_ff @(posedge clk_i) begin
        if (is_code_w) begin
            event_o.code     <= frame_i;
            event_o.extended <= ext_pend_r;
            event_o.brk      <= brk_pend_r;
        end
    end

endmodule

/* hdl/ps2_rx.sv */
`timescale 1ns/10ps

module ps2_rx (
    input  logic                clk_i,
    input  logic                reset_i,
    input  logic                ps2_clk_i,
    input  logic                ps2_data_i,
    output kbd_pkg::scan_code_t frame_o,
    output logic                frame_valid_o,
    output logic                frame_err_o
);

    // two-stage synchronizers, data follows the clock path
    logic [1:0] clk_sync_r;
    logic [1:0] data_sync_r;
    logic       clk_prev_r;

    logic fall_w;
    logic bit_w;

    kbd_pkg::rx_state_t  state_r;
    logic [2:0]          bit_cnt_r;
    kbd_pkg::scan_code_t shift_r;
    // xor of the data bits seen so far
    logic                parity_r;
    logic                parity_ok_r;

    // lines idle high, so the flops reset high to avoid a false edge
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            clk_sync_r  <= 2'b11;
            data_sync_r <= 2'b11;
            clk_prev_r  <= 1'b1;
        end else begin
            clk_sync_r  <= {clk_sync_r[0], ps2_clk_i};
            data_sync_r <= {data_sync_r[0], ps2_data_i};
            clk_prev_r  <= clk_sync_r[1];
        end
    end

    // keyboard changes data on rising edge, we sample on falling edge
    assign fall_w = clk_prev_r & ~clk_sync_r[1];
    assign bit_w  = data_sync_r[1];

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            state_r       <= kbd_pkg::IDLE;
            bit_cnt_r     <= 3'd0;
            parity_r      <= 1'b0;
            parity_ok_r   <= 1'b0;
            frame_valid_o <= 1'b0;
            frame_err_o   <= 1'b0;
        end else begin
            frame_valid_o <= 1'b0;
            frame_err_o   <= 1'b0;
            if (fall_w) begin
                case (state_r)
                    kbd_pkg::IDLE: begin
                        // a low start bit opens the frame
                        if (!bit_w) begin
                            state_r   <= kbd_pkg::DATA;
                            bit_cnt_r <= 3'd0;
                            parity_r  <= 1'b0;
                        end
                    end
                    kbd_pkg::DATA: begin
                        parity_r  <= parity_r ^ bit_w;
                        bit_cnt_r <= bit_cnt_r + 3'd1;
                        if (bit_cnt_r == 3'd7) begin
                            state_r <= kbd_pkg::PARITY;
                        end
                    end
                    kbd_pkg::PARITY: begin
                        // odd parity, data plus parity bit has an odd count of ones
                        parity_ok_r <= parity_r ^ bit_w;
                        state_r     <= kbd_pkg::STOP;
                    end
                    kbd_pkg::STOP: begin
                        state_r <= kbd_pkg::IDLE;
                        if (bit_w && parity_ok_r) begin
                            frame_valid_o <= 1'b1;
                        end else begin
                            frame_err_o <= 1'b1;
                        end
                    end
                    default: begin
                        state_r <= kbd_pkg::IDLE;
                    end
                endcase
            end
        end
    end

    // shift register, lsb arrives first
    always_ff @(posedge clk_i) begin
        if (fall_w && state_r == kbd_pkg::DATA) begin
            shift_r <= {bit_w, shift_r[7:1]};
        end
        if (fall_w && state_r == kbd_pkg::STOP) begin
            frame_o <= shift_r;
        end
    end

endmodule

/* hdl/axil_pkg.sv */
package axil_pkg;

    // bus response codes
    typedef enum logic [1:0] {
        OKAY   = 2'b00,
        SLVERR = 2'b10
    } resp_t;

    // register map, byte addresses
    typedef enum logic [3:0] {
        STATUS_ADDR = 4'h0,
        DATA_ADDR   = 4'h4,
        CTRL_ADDR   = 4'h8
    } reg_addr_t;

    // signals driven by the bus master
    typedef struct packed {
        logic        awvalid;
        logic [3:0]  awaddr;
        logic        wvalid;
        logic [31:0] wdata;
        logic [3:0]  wstrb;
        logic        bready;
        logic        arvalid;
        logic [3:0]  araddr;
        logic        rready;
    } axil_req_t;

    // signals driven by the slave
    typedef struct packed {
        logic        awready;
        logic        wready;
        logic        bvalid;
        resp_t       bresp;
        logic        arready;
        logic        rvalid;
        logic [31:0] rdata;
        resp_t       rresp;
    } axil_rsp_t;

endpackage

/* hdl/kbd_pkg.sv */
package kbd_pkg;

    // one byte as it comes off the PS/2 data line
    typedef logic [7:0] scan_code_t;

    // receiver progress through an 11-bit frame
    // start bit is consumed in IDLE, stop bit in STOP
    typedef enum logic [1:0] {
        IDLE   = 2'b00,
        DATA   = 2'b01,
        PARITY = 2'b10,
        STOP   = 2'b11
    } rx_state_t;

    // decoded key event
    // the field order gives the DATA register layout:
    // code in 7..0, extended in 8, brk in 9
    typedef struct packed {
        logic       brk;
        logic       extended;
        scan_code_t code;
    } key_event_t;

    // prefix bytes of scan code set 2
    localparam scan_code_t PREFIX_EXT = 8'hE0;
    localparam scan_code_t PREFIX_BRK = 8'hF0;

endpackage
